//--- tb.f
verilog/uart_pkg.sv
verilog/uart_byte_if.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_cmd_seq.sv
verilog/uart_cmd_top.sv
tb/tb_uart_cmd.sv

//--- Makefile
TOP = tb_uart_cmd

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/10ps -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee /dev/stderr | grep -q "Result: PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -Wall \
		verilog/uart_pkg.sv verilog/uart_byte_if.sv verilog/uart_rx.sv \
		verilog/uart_tx.sv verilog/uart_cmd_seq.sv verilog/uart_cmd_top.sv \
		--top-module uart_cmd_top

clean:
	rm -rf obj_dir

//--- tb/tb_uart_cmd.sv
`timescale 1ns/10ps

module tb_uart_cmd;

  localparam int clks_per_bit = 8;

  logic                           clk;
  logic                           rst_n;
  logic [uart_pkg::cmd_width-1:0] cmd_in;
  logic                           cmd_vld;
  logic                           rx;
  logic                           tx;
  logic                           cmd_rdy;
  logic                           read_rdy;
  logic [uart_pkg::read_width:0]  read_data;

  integer seed;
  int     err_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     rdy_pulses = 0;

  uart_cmd_top #(
    .CLKS_PER_BIT (clks_per_bit),
    .PARITY_EN    (1'b1)
  ) u_uart_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // read_rdy pulses counted at mid-cycle
  always @(negedge clk) begin
    if (read_rdy === 1'b1) rdy_pulses = rdy_pulses + 1;
  end

  // parity bit that makes the count of ones odd
  function automatic logic odd_parity(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) ones += b[i];
    return (ones % 2 == 0);
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_read(input string name, input logic [8:0] exp, input logic [8:0] act);
    if (act !== exp) begin
      $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("timeout at %0t: no %s arrived in time", $time, what);
    err_cnt++;
  endtask

  task automatic report_test(input string name, input int e0);
    if (err_cnt == e0) pass_cnt++;
    else fail_cnt++;
    $display("test %-14s %s", name, (err_cnt == e0) ? "ok" : "failed");
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic send_cmd(input logic [15:0] cmd);
    int   n;
    logic taken;
    n = 0;
    taken = 1'b0;
    cmd_in = cmd;
    cmd_vld = 1'b1;
    while (!taken && n < 100) begin
      taken = cmd_rdy;
      next_cycle();
      n++;
    end
    cmd_vld = 1'b0;
    if (!taken) note_timeout("cmd_rdy");
  endtask

  // line monitor sampling each bit at its middle
  task automatic get_frame(output logic [7:0] data, output logic par, output logic stop);
    int   n;
    logic prev;
    n = 0;
    prev = tx;
    next_cycle();
    while (!(prev === 1'b1 && tx === 1'b0) && n < 200) begin
      prev = tx;
      next_cycle();
      n++;
    end
    data = '0;
    par = 1'b0;
    stop = 1'b0;
    if (tx !== 1'b0) begin
      note_timeout("start bit on tx");
    end else begin
      wait_cycles(clks_per_bit / 2);
      for (int i = 0; i < 8; i++) begin
        wait_cycles(clks_per_bit);
        data[i] = tx;
      end
      wait_cycles(clks_per_bit);
      par = tx;
      wait_cycles(clks_per_bit);
      stop = tx;
    end
  endtask

  // plays the remote device on rx
  task automatic send_reply(input logic [7:0] b, input logic flip_par, input logic low_stop);
    logic [10:0] frame;
    frame = {~low_stop, odd_parity(b) ^ flip_par, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx = frame[i];
      wait_cycles(clks_per_bit);
    end
    rx = 1'b1;
  endtask

  task automatic wait_read(input int limit, output logic [8:0] data, output logic rdy_then);
    int n;
    n = 0;
    while (read_rdy !== 1'b1 && n < limit) begin
      next_cycle();
      n++;
    end
    data = read_data;
    rdy_then = cmd_rdy;
    if (read_rdy !== 1'b1) note_timeout("read_rdy pulse");
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int n;
    n = 0;
    while (cmd_rdy !== 1'b1 && n < limit) begin
      next_cycle();
      n++;
    end
    if (cmd_rdy !== 1'b1) note_timeout("cmd_rdy after the command");
  endtask

  task automatic test_reset;
    int e0;
    e0 = err_cnt;
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    check_bit("tx", 1'b1, tx);
    check_bit("read_rdy", 1'b0, read_rdy);
    check_read("read_data", 9'h000, read_data);
    report_test("reset", e0);
  endtask

  // disturb adds a stray command and an rx frame during the write
  task automatic run_write(input string name, input logic [15:0] cmd, input logic disturb);
    logic [7:0] b0;
    logic [7:0] b1;
    logic       p0;
    logic       p1;
    logic       s0;
    logic       s1;
    int         e0;
    int         pulses0;
    e0 = err_cnt;
    pulses0 = rdy_pulses;
    send_cmd(cmd);
    check_bit("cmd_rdy", 1'b0, cmd_rdy);
    fork
      begin
        get_frame(b0, p0, s0);
        check_bit("cmd_rdy", 1'b0, cmd_rdy);
        get_frame(b1, p1, s1);
        check_bit("cmd_rdy", 1'b0, cmd_rdy);
      end
      begin
        if (disturb) begin
          wait_cycles(3);
          cmd_in = ~cmd;
          cmd_vld = 1'b1;
          next_cycle();
          cmd_vld = 1'b0;
          wait_cycles(10);
          send_reply(8'($random(seed)), 1'b0, 1'b0);
        end
      end
    join
    check_byte("addr frame", cmd[15:8], b0);
    check_bit("addr parity", odd_parity(cmd[15:8]), p0);
    check_bit("addr stop", 1'b1, s0);
    check_byte("data frame", cmd[7:0], b1);
    check_bit("data parity", odd_parity(cmd[7:0]), p1);
    check_bit("data stop", 1'b1, s1);
    wait_cmd_rdy(4 * clks_per_bit);
    // no third frame may follow the two of this command
    repeat (2 * clks_per_bit) begin
      next_cycle();
      check_bit("tx idle", 1'b1, tx);
    end
    check_bit("read_rdy pulsed", 1'b0, logic'(rdy_pulses != pulses0));
    report_test(name, e0);
  endtask

  // mode selects good reply (0), bad parity (1), low stop (2) or no reply (3)
  task automatic run_read(input string name, input logic [6:0] addr, input int mode);
    logic [7:0] b;
    logic       p;
    logic       s;
    logic [7:0] reply;
    logic [8:0] got;
    logic       rdy_then;
    int         e0;
    int         pulses0;
    e0 = err_cnt;
    pulses0 = rdy_pulses;
    reply = 8'($random(seed));
    send_cmd({1'b1, addr, 8'h5a});
    get_frame(b, p, s);
    check_byte("addr frame", {1'b1, addr}, b);
    check_bit("addr parity", odd_parity({1'b1, addr}), p);
    check_bit("addr stop", 1'b1, s);
    if (mode == 3) begin
      // frame ends half a bit after the stop sample
      wait_read((uart_pkg::resp_timeout_bits + 2) * clks_per_bit + clks_per_bit / 2,
                got, rdy_then);
      check_read("read_data", {1'b1, 8'h00}, got);
    end else begin
      wait_cycles(clks_per_bit);
      fork
        send_reply(reply, mode == 1, mode == 2);
        wait_read(16 * clks_per_bit, got, rdy_then);
      join
      check_read("read_data", {logic'(mode != 0), reply}, got);
    end
    check_bit("cmd_rdy", 1'b1, rdy_then);
    wait_cycles(2);
    check_bit("single read_rdy", 1'b1, logic'(rdy_pulses == pulses0 + 1));
    report_test(name, e0);
  endtask

  initial begin
    seed = 18699;
    rst_n = 1'b0;
    cmd_in = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    test_reset();
    run_write("write", 16'h3ac5, 1'b0);
    run_read("read_good", 7'h12, 0);
    run_read("read_bad_par", 7'h2b, 1);
    run_read("read_bad_stop", 7'h44, 2);
    run_read("read_no_reply", 7'h7f, 3);
    run_write("busy_ignore", 16'h1596, 1'b1);
    $display("tests passed %0d, tests failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/uart_cmd_top.sv
`timescale 1ns/10ps

module uart_cmd_top #(
  parameter int CLKS_PER_BIT = 434,
  parameter bit PARITY_EN    = 1'b1
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  logic                           cmd_vld,
  input  logic                           rx,
  output logic                           tx,
  output logic                           cmd_rdy,
  output logic                           read_rdy,
  output logic [uart_pkg::read_width:0]  read_data
);

  logic [uart_pkg::read_width-1:0] rx_byte;
  logic                            rx_err;
  logic                            rx_valid;
  logic                            rx_active;

  // sequencer to transmitter byte channel
  uart_byte_if u_byte_if ();

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .rx_valid  (rx_valid),
    .rx_active (rx_active)
  );

  uart_cmd_seq #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx_byte   (rx_byte),
    .rx_err    (rx_err),
    .rx_valid  (rx_valid),
    .rx_active (rx_active),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .txb       (u_byte_if.src)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .tx    (tx),
    .txb   (u_byte_if.snk)
  );

endmodule

//--- verilog/uart_cmd_seq.sv
`timescale 1ns/10ps

module uart_cmd_seq #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [uart_pkg::cmd_width-1:0] cmd_in,
  input  logic                          cmd_vld,
  input  logic [uart_pkg::read_width-1:0] rx_byte,
  input  logic                          rx_err,
  input  logic                          rx_valid,
  input  logic                          rx_active,
  output logic                          cmd_rdy,
  output logic                          read_rdy,
  output logic [uart_pkg::read_width:0] read_data,
  uart_byte_if.src                      txb
);

  localparam int to_limit = uart_pkg::resp_timeout_bits * CLKS_PER_BIT;
  localparam int to_w     = $clog2(to_limit);
  localparam logic [to_w-1:0] to_last = to_w'(to_limit - 1);

  uart_pkg::seq_state_t state;
  logic [to_w-1:0]      to_cnt;
  logic                 rw_flag;
  logic [7:0]           wr_byte;
  logic                 accept;
  logic                 timeout_hit;
  logic                 addr_done;

  // ready only between commands and with the line free
  assign cmd_rdy = ((state == uart_pkg::seq_idle) || (state == uart_pkg::seq_done))
                   && !txb.busy;
  assign accept  = cmd_vld & cmd_rdy;

  assign addr_done   = (state == uart_pkg::seq_addr) && txb.done;
  assign timeout_hit = (to_cnt == to_last) && !rx_active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_pkg::seq_idle;
      txb.start <= 1'b0;
      read_rdy  <= 1'b0;
      read_data <= '0;
      to_cnt    <= '0;
    end else begin
      txb.start <= 1'b0;
      read_rdy  <= 1'b0;
      case (state)
        uart_pkg::seq_idle,
        uart_pkg::seq_done: begin
          if (accept) begin
            txb.start <= 1'b1;
            state     <= uart_pkg::seq_addr;
          end else begin
            state <= uart_pkg::seq_idle;
          end
        end
        uart_pkg::seq_addr: begin
          if (txb.done) begin
            if (rw_flag) begin
              to_cnt <= '0;
              state  <= uart_pkg::seq_wait_reply;
            end else begin
              txb.start <= 1'b1;
              state     <= uart_pkg::seq_data;
            end
          end
        end
        uart_pkg::seq_data: begin
          if (txb.done) begin
            state <= uart_pkg::seq_done;
          end
        end
        uart_pkg::seq_wait_reply: begin
          if (rx_valid) begin
            read_data <= {rx_err, rx_byte};
            read_rdy  <= 1'b1;
            state     <= uart_pkg::seq_done;
          end else if (timeout_hit) begin
            read_data <= {1'b1, {uart_pkg::read_width{1'b0}}};
            read_rdy  <= 1'b1;
            state     <= uart_pkg::seq_done;
          end else if (!rx_active) begin
            // held while a reply frame is coming in
            to_cnt <= to_cnt + 1'b1;
          end
        end
        default: state <= uart_pkg::seq_idle;
      endcase
    end
  end

  // command capture and byte selection
  always_ff @(posedge clk) begin
    if (accept) begin
      rw_flag  <= cmd_in[uart_pkg::rw_bit];
      wr_byte  <= cmd_in[7:0];
      txb.data <= cmd_in[uart_pkg::cmd_width-1 -: 8];
    end else if (addr_done && !rw_flag) begin
      txb.data <= wr_byte;
    end
  end

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 434,
  parameter bit PARITY_EN    = 1'b1
) (
  input  logic     clk,
  input  logic     rst_n,
  output logic     tx,
  uart_byte_if.snk txb
);

  localparam int cnt_w = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int bit_w = $clog2(uart_pkg::data_bits);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(CLKS_PER_BIT - 1);
  localparam logic [bit_w-1:0] last_bit = bit_w'(uart_pkg::data_bits - 1);

  uart_pkg::tx_state_t state;
  logic [cnt_w-1:0]    baud_cnt;
  logic [bit_w-1:0]    bit_cnt;
  logic [7:0]          shreg;
  logic                parity;
  logic                bit_end;

  assign bit_end  = (baud_cnt == last_cnt);
  assign txb.busy = (state != uart_pkg::tx_idle);
  assign txb.done = (state == uart_pkg::tx_stop) && bit_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::tx_idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (state == uart_pkg::tx_idle) begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
      if (txb.start) begin
        state <= uart_pkg::tx_start;
      end
    end else if (!bit_end) begin
      baud_cnt <= baud_cnt + 1'b1;
    end else begin
      baud_cnt <= '0;
      case (state)
        uart_pkg::tx_start: state <= uart_pkg::tx_data;
        uart_pkg::tx_data: begin
          if (bit_cnt == last_bit) begin
            state <= PARITY_EN ? uart_pkg::tx_parity : uart_pkg::tx_stop;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        uart_pkg::tx_parity: state <= uart_pkg::tx_stop;
        default: state <= uart_pkg::tx_idle;
      endcase
    end
  end

  // byte latched on start, shifted out lsb first
  always_ff @(posedge clk) begin
    if (state == uart_pkg::tx_idle && txb.start) begin
      shreg  <= txb.data;
      parity <= ~^txb.data;
    end else if (state == uart_pkg::tx_data && bit_end) begin
      shreg <= {1'b0, shreg[7:1]};
    end
  end

  always_comb begin
    case (state)
      uart_pkg::tx_start:  tx = uart_pkg::start_level;
      uart_pkg::tx_data:   tx = shreg[0];
      uart_pkg::tx_parity: tx = parity;
      default:             tx = uart_pkg::stop_level;
    endcase
  end

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 434,
  parameter bit PARITY_EN    = 1'b1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_err,
  output logic       rx_valid,
  output logic       rx_active
);

  localparam int cnt_w = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int bit_w = $clog2(uart_pkg::data_bits);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(CLKS_PER_BIT - 1);
  localparam logic [cnt_w-1:0] half_cnt = cnt_w'(CLKS_PER_BIT / 2 - 1);
  localparam logic [bit_w-1:0] last_bit = bit_w'(uart_pkg::data_bits - 1);

  uart_pkg::rx_state_t state;
  logic                rx_s1;
  logic                rx_s2;
  logic                rx_prev;
  logic [cnt_w-1:0]    cnt;
  logic [bit_w-1:0]    bit_cnt;
  logic                par_acc;
  logic                par_err;
  logic                mid_bit;
  logic                fall;

  assign mid_bit   = (cnt == last_cnt);
  assign fall      = rx_prev & ~rx_s2;
  assign rx_active = (state != uart_pkg::rx_idle);

  // two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::rx_idle;
      cnt      <= '0;
      bit_cnt  <= '0;
      par_acc  <= 1'b0;
      par_err  <= 1'b0;
      rx_err   <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        uart_pkg::rx_idle: begin
          cnt <= '0;
          if (fall) begin
            state <= uart_pkg::rx_start;
          end
        end
        uart_pkg::rx_start: begin
          // half a bit in, start must still be low
          if (cnt == half_cnt) begin
            cnt     <= '0;
            bit_cnt <= '0;
            par_acc <= 1'b0;
            par_err <= 1'b0;
            if (rx_s2 == uart_pkg::start_level) begin
              state <= uart_pkg::rx_data;
            end else begin
              state <= uart_pkg::rx_idle;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::rx_data: begin
          if (mid_bit) begin
            cnt     <= '0;
            par_acc <= par_acc ^ rx_s2;
            if (bit_cnt == last_bit) begin
              state <= PARITY_EN ? uart_pkg::rx_parity : uart_pkg::rx_stop;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::rx_parity: begin
          if (mid_bit) begin
            cnt     <= '0;
            par_err <= ~(par_acc ^ rx_s2);
            state   <= uart_pkg::rx_stop;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        uart_pkg::rx_stop: begin
          if (mid_bit) begin
            cnt      <= '0;
            rx_err   <= par_err | (rx_s2 != uart_pkg::stop_level);
            rx_valid <= 1'b1;
            state    <= uart_pkg::rx_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (state == uart_pkg::rx_data && mid_bit) begin
      rx_byte <= {rx_s2, rx_byte[7:1]};
    end
  end

endmodule

//--- verilog/uart_byte_if.sv
`timescale 1ns/10ps

interface uart_byte_if;

  logic [7:0] data;
  logic       start;
  logic       busy;
  logic       done;

  // sequencer side
  modport src (
    output data,
    output start,
    input  busy,
    input  done
  );

  // transmitter side
  modport snk (
    input  data,
    input  start,
    output busy,
    output done
  );

endinterface

//--- verilog/uart_pkg.sv
package uart_pkg;

  // command layout
  localparam int cmd_width  = 16;
  localparam int rw_bit     = 15;
  localparam int read_width = 8;

  // frame layout
  localparam int   data_bits   = 8;
  localparam logic start_level = 1'b0;
  localparam logic stop_level  = 1'b1;

  // bit periods to wait for a reply start bit
  localparam int resp_timeout_bits = 32;

  typedef enum logic [2:0] {
    seq_idle,
    seq_addr,
    seq_data,
    seq_wait_reply,
    seq_done
  } seq_state_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_t;

endpackage
